/* Bender.yml */
package:
  name: dbus_subsys

sources:
  - files:
      - hdl/dbus_pkg.sv
      - hdl/lsu_align.sv
      - hdl/dbus_router.sv
      - hdl/dbus_mem_model.sv
      - hdl/dbus_subsys_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_dbus_subsys.sv

/* hdl/dbus_mem_model.sv */
`timescale 1ns/10ps

module dbus_mem_model import dbus_pkg::*; #(
	parameter int PIPE_DEPTH = 2,
	parameter int MEM_WORDS  = 1024,
	parameter int LINE_WORDS = 4
)(
	input  logic     clk,
	input  logic     rst,
	input  logic     fake_stall_en,
	input  logic     c_read,
	input  logic     c_write,
	input  logic     u_read,
	input  logic     u_write,
	input  word_t    address,
	input  byte_en_t byteenable,
	input  word_t    wrdata,
	output logic     stall,
	output word_t    c_rddata,
	output word_t    u_rddata
);

	localparam int IDX_BITS  = $clog2(MEM_WORDS);
	localparam int LINE_BITS = $clog2(LINE_WORDS);
	localparam int LINES     = MEM_WORDS / LINE_WORDS;

	word_t            mem [MEM_WORDS];
	logic [LINES-1:0] touched;
	logic [7:0]       timer;

	logic     p_c_read, p_c_write, p_u_read, p_u_write;
	word_t    p_address;
	word_t    p_wrdata;
	byte_en_t p_byteenable;

	logic [IDX_BITS-1:0]           word_idx;
	logic [IDX_BITS-LINE_BITS-1:0] line_idx;
	logic                          active;
	logic                          miss;
	word_t                         rd_word;
	word_t                         merged;

	generate
		if (PIPE_DEPTH == 1) begin : g_stage_comb
			assign p_c_read     = c_read;
			assign p_c_write    = c_write;
			assign p_u_read     = u_read;
			assign p_u_write    = u_write;
			assign p_address    = address;
			assign p_byteenable = byteenable;
			assign p_wrdata     = wrdata;
		end else begin : g_stage_reg
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					p_c_read  <= 1'b0;
					p_c_write <= 1'b0;
					p_u_read  <= 1'b0;
					p_u_write <= 1'b0;
				end else if (~stall) begin
					p_c_read  <= c_read;
					p_c_write <= c_write;
					p_u_read  <= u_read;
					p_u_write <= u_write;
				end
			end

			always_ff @(posedge clk) begin
				if (~stall) begin
					p_address    <= address;
					p_byteenable <= byteenable;
					p_wrdata     <= wrdata;
				end
			end
		end
	endgenerate

	// Low index bits only, so both regions alias.
	assign word_idx = p_address[IDX_BITS+OFFSET_BITS-1:OFFSET_BITS];
	assign line_idx = p_address[IDX_BITS+OFFSET_BITS-1:OFFSET_BITS+LINE_BITS];

	assign active  = p_c_read | p_c_write | p_u_read | p_u_write;
	assign miss    = active & ~touched[line_idx];
	assign stall   = fake_stall_en & (miss | (|timer));
	assign rd_word = mem[word_idx];

	always_comb begin
		for (int b = 0; b < 4; b++) begin
			merged[8*b +: 8] = p_byteenable[b] ? p_wrdata[8*b +: 8] : rd_word[8*b +: 8];
		end
	end

	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if ((p_c_write | p_u_write) & ~stall) begin
			mem[word_idx] <= merged; // Write lands when the item completes.
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			touched <= '0;
		end else if (active) begin
			touched[line_idx] <= 1'b1;
		end
	end

	// Miss penalty, eight or nine cycles depending on the line.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			timer <= '0;
		end else if (fake_stall_en & miss & ~(|timer)) begin
			timer <= 8'h80 >> line_idx[0];
		end else begin
			timer <= timer >> 1;
		end
	end

	assign c_rddata = p_c_read ? rd_word : '0;
	assign u_rddata = p_u_read ? rd_word : '0;

endmodule

/* hdl/dbus_pkg.sv */
package dbus_pkg;

	// Memory operations seen by the load/store front end.
	typedef enum logic [3:0] {
		NOP = 4'd0,
		LB  = 4'd1,
		LBU = 4'd2,
		LH  = 4'd3,
		LHU = 4'd4,
		LW  = 4'd5,
		SB  = 4'd6,
		SH  = 4'd7,
		SW  = 4'd8
	} mem_op_e;

	typedef logic [31:0] word_t;

	// Bit n enables byte lane 8n+7:8n.
	typedef logic [3:0] byte_en_t;

	// Address bits 31:29 of the uncached window.
	localparam logic [2:0] UNCACHED_REGION = 3'b101;

	// Byte offset bits inside a word.
	localparam int OFFSET_BITS = 2;

endpackage

/* hdl/dbus_router.sv */
`timescale 1ns/10ps

module dbus_router import dbus_pkg::*; #(
	parameter int PIPE_DEPTH = 2
)(
	input  logic     clk,
	input  logic     rst,
	input  logic     read,
	input  logic     write,
	input  word_t    address,
	input  byte_en_t byteenable,
	input  word_t    wrdata,
	input  word_t    c_rddata,
	input  word_t    u_rddata,
	input  logic     mem_stall,
	output logic     c_read,
	output logic     c_write,
	output logic     u_read,
	output logic     u_write,
	output word_t    bus_address,
	output byte_en_t bus_byteenable,
	output word_t    bus_wrdata,
	output word_t    rddata,
	output logic     stall
);

	logic uncached;
	logic sel_u;

	assign uncached = (address[31:29] == UNCACHED_REGION);

	assign c_read  = read & ~uncached;
	assign c_write = write & ~uncached;
	assign u_read  = read & uncached;
	assign u_write = write & uncached;

	// Only one bus is active, so the payload is shared.
	assign bus_address    = address;
	assign bus_byteenable = byteenable;
	assign bus_wrdata     = wrdata;

	generate
		if (PIPE_DEPTH == 1) begin : g_sel_comb
			assign sel_u = uncached;
		end else begin : g_sel_reg
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					sel_u <= 1'b0;
				end else if (~mem_stall) begin
					sel_u <= uncached; // Bus of the item entering the stage.
				end
			end
		end
	endgenerate

	assign rddata = sel_u ? u_rddata : c_rddata;
	assign stall  = mem_stall;

endmodule

/* hdl/dbus_subsys_top.sv */
`timescale 1ns/10ps

module dbus_subsys_top import dbus_pkg::*; #(
	parameter int PIPE_DEPTH = 2,
	parameter int MEM_WORDS  = 1024,
	parameter int LINE_WORDS = 4
)(
	input  logic    clk,
	input  logic    rst,
	input  logic    fake_stall_en,
	input  mem_op_e op,
	input  word_t   addr,
	input  word_t   store_data,
	output logic    stall,
	output logic    load_valid,
	output word_t   load_data
);

	// Front end to router.
	logic     read, write;
	word_t    address, wrdata, rddata;
	byte_en_t byteenable;

	// Router to memory model.
	logic     c_read, c_write, u_read, u_write;
	word_t    bus_address, bus_wrdata;
	byte_en_t bus_byteenable;
	word_t    c_rddata, u_rddata;
	logic     mem_stall;

	lsu_align #(
		.PIPE_DEPTH (PIPE_DEPTH)
	) lsu_i (
		.clk        (clk),
		.rst        (rst),
		.op         (op),
		.addr       (addr),
		.store_data (store_data),
		.stall      (stall),
		.rddata     (rddata),
		.read       (read),
		.write      (write),
		.address    (address),
		.byteenable (byteenable),
		.wrdata     (wrdata),
		.load_data  (load_data),
		.load_valid (load_valid)
	);

	dbus_router #(
		.PIPE_DEPTH (PIPE_DEPTH)
	) router_i (
		.clk            (clk),
		.rst            (rst),
		.read           (read),
		.write          (write),
		.address        (address),
		.byteenable     (byteenable),
		.wrdata         (wrdata),
		.c_rddata       (c_rddata),
		.u_rddata       (u_rddata),
		.mem_stall      (mem_stall),
		.c_read         (c_read),
		.c_write        (c_write),
		.u_read         (u_read),
		.u_write        (u_write),
		.bus_address    (bus_address),
		.bus_byteenable (bus_byteenable),
		.bus_wrdata     (bus_wrdata),
		.rddata         (rddata),
		.stall          (stall)
	);

	dbus_mem_model #(
		.PIPE_DEPTH (PIPE_DEPTH),
		.MEM_WORDS  (MEM_WORDS),
		.LINE_WORDS (LINE_WORDS)
	) mem_i (
		.clk           (clk),
		.rst           (rst),
		.fake_stall_en (fake_stall_en),
		.c_read        (c_read),
		.c_write       (c_write),
		.u_read        (u_read),
		.u_write       (u_write),
		.address       (bus_address),
		.byteenable    (bus_byteenable),
		.wrdata        (bus_wrdata),
		.stall         (mem_stall),
		.c_rddata      (c_rddata),
		.u_rddata      (u_rddata)
	);

endmodule

/* hdl/lsu_align.sv */
`timescale 1ns/10ps

module lsu_align import dbus_pkg::*; #(
	parameter int PIPE_DEPTH = 2
)(
	input  logic     clk,
	input  logic     rst,
	input  mem_op_e  op,
	input  word_t    addr,
	input  word_t    store_data,
	input  logic     stall,
	input  word_t    rddata,
	output logic     read,
	output logic     write,
	output word_t    address,
	output byte_en_t byteenable,
	output word_t    wrdata,
	output word_t    load_data,
	output logic     load_valid
);

	function automatic logic is_load(input mem_op_e o);
		return (o == LB) || (o == LBU) || (o == LH) || (o == LHU) || (o == LW);
	endfunction

	mem_op_e                rec_op;
	logic [OFFSET_BITS-1:0] rec_off;
	word_t                  shifted;

	assign address = {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

	// Request decode.
	always_comb begin
		read       = is_load(op);
		write      = (op == SB) || (op == SH) || (op == SW);
		byteenable = '0;
		wrdata     = store_data;
		case (op)
			LB, LBU, SB: begin
				byteenable = 4'b0001 << addr[1:0];
				wrdata     = {4{store_data[7:0]}}; // Byte in every lane.
			end
			LH, LHU, SH: begin
				byteenable = addr[1] ? 4'b1100 : 4'b0011;
				wrdata     = {2{store_data[15:0]}};
			end
			LW, SW: begin
				byteenable = 4'b1111;
			end
			default: begin
				byteenable = '0;
			end
		endcase
	end

	generate
		if (PIPE_DEPTH == 1) begin : g_rec_comb
			// Data returns in the accepting cycle.
			assign rec_op     = op;
			assign rec_off    = addr[OFFSET_BITS-1:0];
			assign load_valid = read & ~stall;
		end else begin : g_rec_reg
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					rec_op <= NOP;
				end else if (~stall) begin
					rec_op <= op;
				end
			end

			always_ff @(posedge clk) begin
				if (~stall) begin
					rec_off <= addr[OFFSET_BITS-1:0];
				end
			end

			assign load_valid = is_load(rec_op) & ~stall; // Stage item completes.
		end
	endgenerate

	assign shifted = rddata >> {rec_off, 3'b000};

	// Lane select and extension of the returned word.
	always_comb begin
		case (rec_op)
			LB:      load_data = {{24{shifted[7]}}, shifted[7:0]};
			LBU:     load_data = {24'd0, shifted[7:0]};
			LH:      load_data = {{16{shifted[15]}}, shifted[15:0]};
			LHU:     load_data = {16'd0, shifted[15:0]};
			default: load_data = rddata;
		endcase
	end

endmodule

/* testbench/tb_dbus_ref_model.svh */
`ifndef TB_DBUS_REF_MODEL_SVH
`define TB_DBUS_REF_MODEL_SVH

// Byte image of the word array, indexed by the low address bits only.
localparam int REF_BYTES = 4096;

logic [7:0]   ref_mem [REF_BYTES];
logic [255:0] line_seen; // Lines touched since reset.

function automatic int byte_index(input word_t a);
	return int'(a[11:0]);
endfunction

function automatic int line_of(input word_t a);
	return int'(a[11:4]); // Four words per line.
endfunction

task automatic ref_clear();
	for (int i = 0; i < REF_BYTES; i++) begin
		ref_mem[i] = 8'h00;
	end
	line_seen = '0;
endtask

// Little endian, so byte n of the data lands at address a + n.
task automatic ref_store(input mem_op_e o, input word_t a, input word_t d);
	int n;
	n = (o == SB) ? 1 : ((o == SH) ? 2 : 4);
	for (int i = 0; i < n; i++) begin
		ref_mem[byte_index(a) + i] = d[8*i +: 8];
	end
endtask

function automatic word_t ref_load(input mem_op_e o, input word_t a);
	int base;
	base = byte_index(a);
	case (o)
		LB:      return {{24{ref_mem[base][7]}}, ref_mem[base]};
		LBU:     return {24'd0, ref_mem[base]};
		LH:      return {{16{ref_mem[base + 1][7]}}, ref_mem[base + 1], ref_mem[base]};
		LHU:     return {16'd0, ref_mem[base + 1], ref_mem[base]};
		default: return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
	endcase
endfunction

`endif

/* testbench/tb_dbus_subsys.sv */
`timescale 1ns/10ps

module tb_dbus_subsys import dbus_pkg::*; ();

	localparam int STALL_OPS   = 300; // Mixed traffic with miss emulation on.
	localparam int ALIAS_WORDS = 64;
	localparam int FREE_OPS    = 172;
	localparam int NUM_OPS     = STALL_OPS + 2 * ALIAS_WORDS + FREE_OPS;
	localparam int MAX_CYCLES  = 40 * NUM_OPS;

	logic    clk;
	logic    rst;
	logic    fake_stall_en;
	mem_op_e op;
	word_t   addr;
	word_t   store_data;
	logic    stall;
	logic    load_valid;
	word_t   load_data;

	integer  seed;
	int      errors;
	int      cycles;
	int      issued;
	int      loads_issued;
	int      loads_done;
	logic    prev_active;
	logic    prev_miss;
	logic    prev_load;
	word_t   expected_q[$];
	word_t   alias_addr[ALIAS_WORDS];

	`include "tb_dbus_ref_model.svh"

	dbus_subsys_top #(
		.PIPE_DEPTH (2),
		.MEM_WORDS  (1024),
		.LINE_WORDS (4)
	) dut_i (
		.clk           (clk),
		.rst           (rst),
		.fake_stall_en (fake_stall_en),
		.op            (op),
		.addr          (addr),
		.store_data    (store_data),
		.stall         (stall),
		.load_valid    (load_valid),
		.load_data     (load_data)
	);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// Random address in the first 256 words of either region, aligned to the size.
	function automatic word_t random_addr(input mem_op_e o);
		word_t r;
		word_t a;
		r = $random(seed);
		a = {(r[31] ? UNCACHED_REGION : 3'b000), 19'd0, r[9:2], 2'b00};
		case (o)
			LB, LBU, SB: a[1:0] = r[1:0];
			LH, LHU, SH: a[1] = r[1];
			default:     a[1:0] = 2'b00;
		endcase
		return a;
	endfunction

	// Presents one operation and returns at the edge that accepts it.
	task automatic issue_op(input mem_op_e o, input word_t a, input word_t d);
		int waited;
		op         <= o;
		addr       <= a;
		store_data <= d;
		waited = 0;
		do begin
			@(posedge clk);
			if ((waited == 0) && prev_active) begin
				check_value("stall", {31'd0, prev_miss}, {31'd0, stall}); // Item in stage.
			end
			// A load in the stage completes at the first edge with stall low.
			check_value("load_valid", {31'd0, prev_load && !stall}, {31'd0, load_valid});
			waited++;
		end while (stall);
		prev_active = (o != NOP);
		prev_miss   = fake_stall_en && prev_active && !line_seen[line_of(a)];
		prev_load   = 1'b0;
		if (prev_active) begin
			line_seen[line_of(a)] = 1'b1;
		end
		case (o)
			SB, SH, SW: ref_store(o, a, d);
			LB, LBU, LH, LHU, LW: begin
				expected_q.push_back(ref_load(o, a));
				loads_issued++;
				prev_load = 1'b1;
			end
			default: ;
		endcase
		issued++;
	endtask

	// Each completed load takes the oldest expected value.
	always @(posedge clk) begin
		if (!rst && load_valid) begin
			if (expected_q.size() == 0) begin
				errors++;
				$display("Load completed at %0t ns with no load outstanding.", $time);
			end else begin
				check_value("load_data", expected_q.pop_front(), load_data);
				loads_done++;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles with %0d of %0d operations issued.",
			cycles, issued, NUM_OPS);
		$display("Operations %0d, loads checked %0d, errors %0d", issued, loads_done, errors + 1);
		$display("Test failed");
		$finish;
	end

	initial begin
		word_t   a;
		mem_op_e o;
		seed          = 51178;
		errors        = 0;
		issued        = 0;
		loads_issued  = 0;
		loads_done    = 0;
		prev_active   = 1'b0;
		prev_miss     = 1'b0;
		prev_load     = 1'b0;
		clk           = 1'b0;
		rst           = 1'b1;
		fake_stall_en = 1'b1;
		op            = NOP;
		addr          = '0;
		store_data    = '0;
		ref_clear();
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < STALL_OPS; i++) begin
			o = mem_op_e'($unsigned($random(seed)) % 9);
			issue_op(o, random_addr(o), $random(seed));
		end

		// Switch modes only with a NOP in the stage.
		issue_op(NOP, '0, '0);
		fake_stall_en <= 1'b0;

		for (int i = 0; i < ALIAS_WORDS; i++) begin
			alias_addr[i] = random_addr(SW);
			issue_op(SW, alias_addr[i], $random(seed));
		end
		for (int i = 0; i < ALIAS_WORDS; i++) begin
			a = alias_addr[i] ^ 32'hA000_0000; // Same word through the other region.
			issue_op(LW, a, '0);
		end

		for (int i = 0; i < FREE_OPS; i++) begin
			o = mem_op_e'($unsigned($random(seed)) % 9);
			issue_op(o, random_addr(o), $random(seed));
		end

		issue_op(NOP, '0, '0);
		@(posedge clk);
		if (expected_q.size() != 0) begin
			errors++;
			$display("%0d of %0d loads never completed.", expected_q.size(), loads_issued);
		end
		$display("Operations %0d, loads checked %0d, errors %0d", issued, loads_done, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+testbench
hdl/dbus_pkg.sv
hdl/lsu_align.sv
hdl/dbus_router.sv
hdl/dbus_mem_model.sv
hdl/dbus_subsys_top.sv
testbench/tb_dbus_subsys.sv
